// ==== rtl/spim_pkg.sv ====
`default_nettype none

package spim_pkg;

  // ------------------------------
  // Widths that carry a meaning
  // ------------------------------

  // One flash byte such as an opcode
  typedef logic [7:0]  spim_byte_t;
  // Address, data and APB data word
  typedef logic [31:0] spim_word_t;
  // APB register offset
  typedef logic [4:0]  spim_apb_addr_t;
  // Byte count minus one so 0 means one byte
  typedef logic [1:0]  spim_len_t;
  // SPI clock divider
  typedef logic [5:0]  spim_div_t;
  // Bits left in a shift of up to 32
  typedef logic [5:0]  spim_bitcnt_t;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam spim_apb_addr_t REG_CFG    = 5'h00;
  localparam spim_apb_addr_t REG_CMD    = 5'h04;
  localparam spim_apb_addr_t REG_ADDR   = 5'h08;
  localparam spim_apb_addr_t REG_WDATA  = 5'h0C;
  localparam spim_apb_addr_t REG_RDATA  = 5'h10;
  localparam spim_apb_addr_t REG_STATUS = 5'h14;

  // Flash phase sequence codes
  typedef enum logic [3:0] {
    SEQ_C    = 4'd0,   // Command only
    SEQ_CA   = 4'd2,   // Command, address
    SEQ_CAR  = 4'd3,   // Command, address, read
    SEQ_CADR = 4'd4,   // Command, address, dummy, read
    SEQ_CAW  = 4'd7,   // Command, address, write
    SEQ_CR   = 4'd11   // Command, read
  } spim_seq_e;

  // Sequencer FSM states
  typedef enum logic [2:0] {
    IDLE, CS_LEAD, CMD, ADDR, DUMMY, WRITE, READ, CS_LAG
  } spim_state_e;

  // Static configuration from REG_CFG
  typedef struct packed {
    spim_div_t  div;
    logic [1:0] cs_sel;
    logic [1:0] cs_lead;
    logic [1:0] cs_lag;
  } spim_cfg_t;

  // One flash transaction as seen by the sequencer
  typedef struct packed {
    spim_byte_t opcode;
    spim_len_t  addr_len;
    spim_len_t  dummy_len;
    spim_len_t  data_len;
    spim_seq_e  seq;
    spim_word_t addr;
    spim_word_t wdata;
  } spim_cmd_t;

  // Shift request with data MSB aligned for sending
  typedef struct packed {
    logic         load;
    logic         rx;
    spim_bitcnt_t bits;
    spim_word_t   data;
  } spim_shift_req_t;

endpackage

`default_nettype wire

// ==== rtl/spim_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module spim_regs (
  input  wire                         clk,
  input  wire                         rstn,
  // APB slave, zero wait states
  input  wire                         psel,
  input  wire                         penable,
  input  wire                         pwrite,
  input  spim_pkg::spim_apb_addr_t    paddr,
  input  spim_pkg::spim_word_t        pwdata,
  output spim_pkg::spim_word_t        prdata,
  // Towards the sequencer
  output spim_pkg::spim_cfg_t         cfg,
  output spim_pkg::spim_cmd_t         cmd,
  output logic                        start,
  input  wire                         busy,
  input  wire                         rdata_valid,
  input  spim_pkg::spim_word_t        rdata
);

  logic                 wr_en;
  logic                 cmd_accept;
  spim_pkg::spim_word_t rdata_q;

  // Write strobe in the APB access phase
  assign wr_en = psel & penable & pwrite;

  // A new command only when nothing is running or about to start
  assign cmd_accept = wr_en & (paddr == spim_pkg::REG_CMD) & ~busy & ~start;

  // ------------------------------
  // Control registers
  // ------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg   <= '0;
      start <= 1'b0;
    end else begin
      // Start pulses in the cycle after the accepted write
      start <= cmd_accept;
      if (wr_en && (paddr == spim_pkg::REG_CFG)) begin
        cfg.div     <= pwdata[5:0];
        cfg.cs_sel  <= pwdata[9:8];
        cfg.cs_lead <= pwdata[11:10];
        cfg.cs_lag  <= pwdata[13:12];
      end
    end
  end

  // ------------------------------
  // Command and data registers
  // ------------------------------
  always_ff @(posedge clk) begin
    if (cmd_accept) begin
      cmd.opcode    <= pwdata[7:0];
      cmd.addr_len  <= pwdata[9:8];
      cmd.dummy_len <= pwdata[11:10];
      cmd.data_len  <= pwdata[13:12];
      cmd.seq       <= spim_pkg::spim_seq_e'(pwdata[19:16]);
    end
    if (wr_en && (paddr == spim_pkg::REG_ADDR)) begin
      cmd.addr <= pwdata;
    end
    if (wr_en && (paddr == spim_pkg::REG_WDATA)) begin
      cmd.wdata <= pwdata;
    end
    // Read result lands once per read phase
    if (rdata_valid) begin
      rdata_q <= rdata;
    end
  end

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    prdata = '0;
    case (paddr)
      spim_pkg::REG_CFG: begin
        prdata[5:0]   = cfg.div;
        prdata[9:8]   = cfg.cs_sel;
        prdata[11:10] = cfg.cs_lead;
        prdata[13:12] = cfg.cs_lag;
      end
      spim_pkg::REG_CMD: begin
        prdata[7:0]   = cmd.opcode;
        prdata[9:8]   = cmd.addr_len;
        prdata[11:10] = cmd.dummy_len;
        prdata[13:12] = cmd.data_len;
        prdata[19:16] = cmd.seq;
      end
      spim_pkg::REG_ADDR: begin
        prdata = cmd.addr;
      end
      spim_pkg::REG_WDATA: begin
        prdata = cmd.wdata;
      end
      spim_pkg::REG_RDATA: begin
        prdata = rdata_q;
      end
      // Busy also covers the start cycle before the FSM leaves idle
      spim_pkg::REG_STATUS: begin
        prdata[0] = busy | start;
      end
      default: begin
        prdata = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/spim_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module spim_clkgen (
  input  wire                  clk,
  input  wire                  rstn,
  input  wire                  en,
  input  spim_pkg::spim_div_t  div,
  output logic                 spi_clk,
  output logic                 spi_rise,
  output logic                 spi_fall
);

  spim_pkg::spim_div_t cnt;
  logic                tick;

  // Half period ends when the counter reaches the divider
  assign tick = en & (cnt == div);

  // Edge strobes lead the spi_clk flop by one cycle
  assign spi_rise = tick & ~spi_clk;
  assign spi_fall = tick & spi_clk;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt     <= '0;
      spi_clk <= 1'b0;
    end else if (!en) begin
      // Park low so the next shift starts with a rise
      cnt     <= '0;
      spi_clk <= 1'b0;
    end else if (tick) begin
      cnt     <= '0;
      spi_clk <= ~spi_clk;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/spim_shift.sv ====
`timescale 1ns/100ps
`default_nettype none

module spim_shift (
  input  wire                        clk,
  input  wire                        rstn,
  // Shift request from the sequencer
  input  spim_pkg::spim_shift_req_t  req,
  // Edge strobes from the clock generator
  input  wire                        spi_rise,
  input  wire                        spi_fall,
  // Serial lines
  input  wire                        sdi,
  output logic                       sdo,
  // Status back
  output logic                       clk_en,
  output logic                       done,
  output spim_pkg::spim_word_t       rx_data
);

  logic                   active;
  logic                   rx_mode;
  spim_pkg::spim_bitcnt_t bit_cnt;
  spim_pkg::spim_word_t   shreg;

  // ------------------------------
  // Bit counter and handshake
  // ------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      active  <= 1'b0;
      rx_mode <= 1'b0;
      bit_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (req.load) begin
        active  <= 1'b1;
        rx_mode <= req.rx;
        bit_cnt <= req.bits;
      end else if (active && spi_rise) begin
        // Every rise consumes one bit, in both directions
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == 6'd1) begin
          // Last rise, stop the clock and report next cycle
          active <= 1'b0;
          done   <= 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // Data shift register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (req.load) begin
      // Receive starts from zero so short reads end up in the low bits
      shreg <= req.rx ? '0 : req.data;
    end else if (active) begin
      if (rx_mode && spi_rise) begin
        shreg <= {shreg[30:0], sdi};
      end else if (!rx_mode && spi_fall) begin
        // Next bit moves up to the top on the falling edge
        shreg <= {shreg[30:0], 1'b0};
      end
    end
  end

  // First bit goes out already in the load cycle
  always_comb begin
    if (req.load) begin
      sdo = ~req.rx & req.data[31];
    end else begin
      sdo = active & ~rx_mode & shreg[31];
    end
  end

  // SPI clock runs only while bits are left
  assign clk_en = active;

  // Raw sampled bits, the last bit received sits in bit 0
  assign rx_data = shreg;

endmodule

`default_nettype wire

// ==== rtl/spim_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module spim_seq #(
  parameter int NUM_CS = 4
) (
  input  wire                         clk,
  input  wire                         rstn,
  // From the register block
  input  spim_pkg::spim_cfg_t         cfg,
  input  spim_pkg::spim_cmd_t         cmd,
  input  wire                         start,
  output logic                        busy,
  output logic                        rdata_valid,
  output spim_pkg::spim_word_t        rdata,
  // Shifter handshake
  output spim_pkg::spim_shift_req_t   req,
  input  wire                         done,
  input  spim_pkg::spim_word_t        rx_data,
  // Active low chip selects
  output logic [NUM_CS-1:0]           csn
);

  spim_pkg::spim_state_e state;
  spim_pkg::spim_state_e state_nxt;
  spim_pkg::spim_cmd_t   cmd_q;
  logic [1:0]            cs_cnt;
  logic [1:0]            cs_cnt_nxt;
  logic                  load_q;
  logic                  load_nxt;
  logic [NUM_CS-1:0]     cs_on;

  // Phase order per sequence, CS_LAG means no phase is left
  function automatic spim_pkg::spim_state_e next_phase(
    input spim_pkg::spim_state_e cur,
    input spim_pkg::spim_seq_e   seq
  );
    next_phase = spim_pkg::CS_LAG;
    case (cur)
      spim_pkg::CMD: begin
        case (seq)
          spim_pkg::SEQ_CA, spim_pkg::SEQ_CAR,
          spim_pkg::SEQ_CADR, spim_pkg::SEQ_CAW: next_phase = spim_pkg::ADDR;
          spim_pkg::SEQ_CR:                      next_phase = spim_pkg::READ;
          default:                               next_phase = spim_pkg::CS_LAG;
        endcase
      end
      spim_pkg::ADDR: begin
        case (seq)
          spim_pkg::SEQ_CAR:  next_phase = spim_pkg::READ;
          spim_pkg::SEQ_CADR: next_phase = spim_pkg::DUMMY;
          spim_pkg::SEQ_CAW:  next_phase = spim_pkg::WRITE;
          default:            next_phase = spim_pkg::CS_LAG;
        endcase
      end
      spim_pkg::DUMMY: next_phase = spim_pkg::READ;
      default:         next_phase = spim_pkg::CS_LAG;
    endcase
  endfunction

  // Byte length field to bit count
  function automatic spim_pkg::spim_bitcnt_t len_bits(input spim_pkg::spim_len_t len);
    len_bits = {1'b0, len, 3'b000} + 6'd8;
  endfunction

  // ------------------------------
  // Phase FSM
  // ------------------------------
  always_comb begin
    state_nxt  = state;
    cs_cnt_nxt = cs_cnt;
    load_nxt   = 1'b0;
    case (state)
      spim_pkg::IDLE: begin
        if (start) begin
          state_nxt  = spim_pkg::CS_LEAD;
          cs_cnt_nxt = '0;
        end
      end
      // Setup time between chip select and the first clock
      spim_pkg::CS_LEAD: begin
        if (cs_cnt == cfg.cs_lead) begin
          state_nxt = spim_pkg::CMD;
          load_nxt  = 1'b1;
        end else begin
          cs_cnt_nxt = cs_cnt + 1'b1;
        end
      end
      // Hold time, the cycle of the last done counts as the first
      spim_pkg::CS_LAG: begin
        if (cs_cnt == cfg.cs_lag) begin
          state_nxt = spim_pkg::IDLE;
        end else begin
          cs_cnt_nxt = cs_cnt + 1'b1;
        end
      end
      // Any shift phase waits for the shifter
      default: begin
        if (done) begin
          state_nxt = next_phase(state, cmd_q.seq);
          if (state_nxt == spim_pkg::CS_LAG) begin
            cs_cnt_nxt = 2'd1;
            if (cfg.cs_lag == 2'd0) begin
              state_nxt = spim_pkg::IDLE;
            end
          end else begin
            load_nxt = 1'b1;
          end
        end
      end
    endcase
  end

  // Chip select decode, an out of range select drives none
  always_comb begin
    cs_on = '0;
    for (int i = 0; i < NUM_CS; i++) begin
      cs_on[i] = (cfg.cs_sel == i);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state  <= spim_pkg::IDLE;
      cs_cnt <= '0;
      load_q <= 1'b0;
      csn    <= '1;
    end else begin
      state  <= state_nxt;
      cs_cnt <= cs_cnt_nxt;
      load_q <= load_nxt;
      // Chip select follows the next state so it leaves with busy
      csn    <= (state_nxt == spim_pkg::IDLE) ? '1 : ~cs_on;
    end
  end

  // Transaction copy, frees the registers for the next command
  always_ff @(posedge clk) begin
    if (start && (state == spim_pkg::IDLE)) begin
      cmd_q <= cmd;
    end
  end

  // ------------------------------
  // Shift requests
  // ------------------------------
  always_comb begin
    req.load = load_q;
    req.rx   = 1'b0;
    req.bits = 6'd8;
    req.data = '0;
    case (state)
      spim_pkg::CMD: begin
        req.data = {cmd_q.opcode, 24'h0};
      end
      spim_pkg::ADDR: begin
        // Left align the used address bytes
        req.bits = len_bits(cmd_q.addr_len);
        req.data = cmd_q.addr << {~cmd_q.addr_len, 3'b000};
      end
      spim_pkg::DUMMY: begin
        req.bits = len_bits(cmd_q.dummy_len);
      end
      spim_pkg::WRITE: begin
        // Byte 0 goes out first, each byte MSB first
        req.bits = len_bits(cmd_q.data_len);
        req.data = {cmd_q.wdata[7:0], cmd_q.wdata[15:8],
                    cmd_q.wdata[23:16], cmd_q.wdata[31:24]};
      end
      spim_pkg::READ: begin
        req.rx   = 1'b1;
        req.bits = len_bits(cmd_q.data_len);
      end
      default: begin
        req.load = load_q;
      end
    endcase
  end

  // ------------------------------
  // Read data, little endian
  // ------------------------------
  always_comb begin
    int src;
    rdata = '0;
    for (int k = 0; k < 4; k++) begin
      // First received byte sits highest in the shifter
      src = int'(cmd_q.data_len) - k;
      if (src >= 0) begin
        rdata[8*k +: 8] = rx_data[8*src +: 8];
      end
    end
  end

  assign rdata_valid = (state == spim_pkg::READ) & done;
  assign busy        = (state != spim_pkg::IDLE);

endmodule

`default_nettype wire

// ==== rtl/spim_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module spim_top #(
  parameter int NUM_CS = 4
) (
  input  wire                       clk,
  input  wire                       rstn,
  // APB slave
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  spim_pkg::spim_apb_addr_t  paddr,
  input  spim_pkg::spim_word_t      pwdata,
  output spim_pkg::spim_word_t      prdata,
  // SPI flash pins
  output logic                      spi_clk,
  output logic [NUM_CS-1:0]         csn,
  output logic                      sdo,
  input  wire                       sdi
);

  // ------------------------------
  // Internal nets
  // ------------------------------
  spim_pkg::spim_cfg_t       cfg;
  spim_pkg::spim_cmd_t       cmd;
  logic                      start;
  logic                      busy;
  logic                      rdata_valid;
  spim_pkg::spim_word_t      rdata;
  spim_pkg::spim_shift_req_t req;
  logic                      done;
  spim_pkg::spim_word_t      rx_data;
  logic                      clk_en;
  logic                      spi_rise;
  logic                      spi_fall;

  // Software view, configuration and command
  spim_regs u_regs (
    .clk (clk), .rstn (rstn),
    .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
    .cfg (cfg), .cmd (cmd), .start (start),
    .busy (busy), .rdata_valid (rdata_valid), .rdata (rdata)
  );

  // Phase sequencing and chip select timing
  spim_seq #(.NUM_CS (NUM_CS)) u_seq (
    .clk (clk), .rstn (rstn),
    .cfg (cfg), .cmd (cmd), .start (start),
    .busy (busy), .rdata_valid (rdata_valid), .rdata (rdata),
    .req (req), .done (done), .rx_data (rx_data), .csn (csn)
  );

  // Serial data path
  spim_shift u_shift (
    .clk (clk), .rstn (rstn), .req (req),
    .spi_rise (spi_rise), .spi_fall (spi_fall),
    .sdi (sdi), .sdo (sdo),
    .clk_en (clk_en), .done (done), .rx_data (rx_data)
  );

  // SPI clock from the configured divider
  spim_clkgen u_clkgen (
    .clk (clk), .rstn (rstn), .en (clk_en), .div (cfg.div),
    .spi_clk (spi_clk), .spi_rise (spi_rise), .spi_fall (spi_fall)
  );

endmodule

`default_nettype wire

// ==== sim/spi_flash_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_flash_model (
  input  wire        clk,
  input  wire        cs_n,
  input  wire        spi_clk,
  input  wire        sdo,
  output logic       sdi,
  // Word returned MSB first, after rd_start bytes of the frame
  input  wire [31:0] rd_word,
  input  wire [3:0]  rd_start
);

  // Received bytes in arrival order, across all frames
  logic [7:0] log_mem [0:63];
  int         log_cnt;
  int         frame_cnt;
  int         bit_cnt;
  int         rd_idx;
  logic [7:0] rx_byte;
  logic       sdo_low;

  initial begin
    log_cnt   = 0;
    frame_cnt = 0;
    bit_cnt   = 0;
    rx_byte   = 8'h00;
    sdo_low   = 1'b0;
    sdi       = 1'b0;
  end

  // Master moves sdo on the falling edge, so take it while spi_clk is low
  always @(negedge clk) begin
    if (!spi_clk) begin
      sdo_low <= sdo;
    end
  end

  always @(negedge cs_n) begin
    frame_cnt <= frame_cnt + 1;
  end

  // ------------------------------
  // Receive side, one bit per rise
  // ------------------------------
  always @(posedge spi_clk or posedge cs_n) begin
    if (cs_n) begin
      bit_cnt <= 0;
    end else begin
      bit_cnt <= bit_cnt + 1;
      rx_byte <= {rx_byte[6:0], sdo_low};
      // Eighth bit completes a byte
      if ((bit_cnt % 8 == 7) && (log_cnt < 64)) begin
        log_mem[log_cnt] <= {rx_byte[6:0], sdo_low};
        log_cnt          <= log_cnt + 1;
      end
    end
  end

  // Send side, next bit set up on the falling edge for the following rise
  always @(negedge spi_clk or negedge cs_n) begin
    rd_idx = bit_cnt - 8 * int'(rd_start);
    if ((rd_idx >= 0) && (rd_idx < 32)) begin
      sdi <= rd_word[31 - rd_idx];
    end else begin
      sdi <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_spim.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_spim;

  localparam int NUM_CS    = 4;
  localparam int CS_USED   = 2;
  localparam int CLK_NS    = 8;
  localparam int DIV       = 1;
  localparam int NUM_TESTS = 6;
  // Longest frame is 8 + 32 + 32 + 32 bits of two half periods of DIV+1 clocks each
  localparam int TXN_CYCLES  = 104 * 2 * (DIV + 1) + 120;
  // Each test runs at most two frames plus its register traffic
  localparam int WATCHDOG_NS = (NUM_TESTS * 2 * TXN_CYCLES + 20) * CLK_NS;

  // Register offsets
  localparam logic [4:0] REG_CFG    = 5'h00;
  localparam logic [4:0] REG_CMD    = 5'h04;
  localparam logic [4:0] REG_ADDR   = 5'h08;
  localparam logic [4:0] REG_WDATA  = 5'h0C;
  localparam logic [4:0] REG_RDATA  = 5'h10;
  localparam logic [4:0] REG_STATUS = 5'h14;
  // Sequence codes
  localparam logic [3:0] SEQ_C    = 4'd0;
  localparam logic [3:0] SEQ_CA   = 4'd2;
  localparam logic [3:0] SEQ_CAR  = 4'd3;
  localparam logic [3:0] SEQ_CADR = 4'd4;
  localparam logic [3:0] SEQ_CAW  = 4'd7;
  localparam logic [3:0] SEQ_CR   = 4'd11;

  logic              clk;
  logic              rstn;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [4:0]        paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              spi_clk;
  logic [NUM_CS-1:0] csn;
  logic              sdo;
  logic              sdi;
  logic [31:0]       rd_word;
  logic [3:0]        rd_start;
  logic              cs_clear;
  logic [NUM_CS-1:0] cs_seen;
  logic [7:0]        exp_log [0:15];
  int                exp_len;
  int                err_cnt;
  int                pass_cnt;
  int                fail_cnt;

  spim_top #(.NUM_CS (NUM_CS)) DUT (
    .clk (clk), .rstn (rstn),
    .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
    .spi_clk (spi_clk), .csn (csn), .sdo (sdo), .sdi (sdi)
  );

  spi_flash_model flash (
    .clk (clk), .cs_n (csn[CS_USED]), .spi_clk (spi_clk),
    .sdo (sdo), .sdi (sdi), .rd_word (rd_word), .rd_start (rd_start)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // Chip select lines that went low since the last clear
  always @(negedge clk) begin
    if (cs_clear) begin
      cs_seen <= '0;
    end else begin
      cs_seen <= cs_seen | ~csn;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // Read data is taken mid access phase
  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // Poll the busy flag until the frame is over
  task automatic wait_idle();
    logic [31:0] st;
    st = 32'h1;
    while (st[0]) begin
      apb_read(REG_STATUS, st);
    end
  endtask

  task automatic send_cmd(input logic [7:0] opcode, input logic [1:0] alen,
                          input logic [1:0] dlen, input logic [1:0] len,
                          input logic [3:0] seq);
    apb_write(REG_CMD, {12'h0, seq, 2'b00, len, dlen, alen, opcode});
  endtask

  task automatic clear_cs_monitor();
    @(posedge clk);
    cs_clear <= 1'b1;
    @(posedge clk);
    cs_clear <= 1'b0;
  endtask

  task automatic expect_byte(input logic [7:0] b);
    exp_log[exp_len] = b;
    exp_len++;
  endtask

  // Address goes out MSB first over its used bytes
  task automatic expect_addr(input logic [31:0] addr, input int alen);
    for (int i = alen; i >= 0; i--) begin
      expect_byte(addr[8*i +: 8]);
    end
  endtask

  // Compares the expected head of the log and the total byte count
  task automatic compare_log(input int base, input int total);
    check_value("log length", flash.log_cnt - base, total);
    for (int i = 0; i < exp_len; i++) begin
      if (base + i < flash.log_cnt) begin
        check_value($sformatf("log byte %0d", i), flash.log_mem[base + i], exp_log[i]);
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("test %s: passed", name);
      pass_cnt++;
    end else begin
      $display("test %s: failed with %0d mismatches", name, err_cnt - errs_before);
      fail_cnt++;
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_reset();
    int          errs;
    logic [31:0] val;
    logic [31:0] cfg_word;
    errs     = err_cnt;
    // Lag 2 and lead 1 on chip select CS_USED with divider DIV
    cfg_word = {18'h0, 2'd2, 2'd1, 2'(CS_USED), 2'b00, 6'(DIV)};
    @(negedge clk);
    check_value("csn", csn, {NUM_CS{1'b1}});
    check_value("spi_clk", spi_clk, 32'h0);
    check_value("sdo", sdo, 32'h0);
    apb_read(REG_STATUS, val);
    check_value("status", val, 32'h0);
    apb_write(REG_CFG, cfg_word);
    apb_read(REG_CFG, val);
    check_value("cfg", val, cfg_word);
    report_test("reset", errs);
  endtask

  task automatic test_cmd_only();
    int errs;
    int base;
    int frames;
    errs   = err_cnt;
    base   = flash.log_cnt;
    frames = flash.frame_cnt;
    clear_cs_monitor();
    send_cmd(8'h06, 2'd0, 2'd0, 2'd0, SEQ_C);
    wait_idle();
    exp_len = 0;
    expect_byte(8'h06);
    compare_log(base, 1);
    check_value("frames", flash.frame_cnt - frames, 32'd1);
    check_value("cs_seen", cs_seen, 32'd1 << CS_USED);
    check_value("csn", csn, {NUM_CS{1'b1}});
    report_test("command only", errs);
  endtask

  task automatic test_cmd_addr();
    int errs;
    int base;
    errs = err_cnt;
    base = flash.log_cnt;
    // Top byte lies outside a 3-byte address
    apb_write(REG_ADDR, 32'hAB12_3456);
    send_cmd(8'h20, 2'd2, 2'd0, 2'd0, SEQ_CA);
    wait_idle();
    exp_len = 0;
    expect_byte(8'h20);
    expect_addr(32'hAB12_3456, 2);
    compare_log(base, 4);
    report_test("command address", errs);
  endtask

  task automatic test_write();
    int errs;
    int base;
    errs = err_cnt;
    base = flash.log_cnt;
    apb_write(REG_ADDR, 32'h89AB_CDEF);
    apb_write(REG_WDATA, 32'h4433_2211);
    send_cmd(8'h02, 2'd3, 2'd0, 2'd3, SEQ_CAW);
    wait_idle();
    exp_len = 0;
    expect_byte(8'h02);
    expect_addr(32'h89AB_CDEF, 3);
    // Byte 0 of the write word leads
    for (int i = 0; i < 4; i++) begin
      expect_byte(8'(32'h4433_2211 >> (8 * i)));
    end
    compare_log(base, 9);
    report_test("address write", errs);
  endtask

  task automatic test_read();
    int          errs;
    int          base;
    logic [31:0] val;
    errs = err_cnt;
    base = flash.log_cnt;
    // Reply starts after opcode, 3 address bytes and 1 dummy byte
    @(posedge clk);
    rd_word  <= 32'hA53C_96E1;
    rd_start <= 4'd5;
    apb_write(REG_ADDR, 32'h0004_0506);
    send_cmd(8'h0B, 2'd2, 2'd0, 2'd1, SEQ_CADR);
    wait_idle();
    exp_len = 0;
    expect_byte(8'h0B);
    expect_addr(32'h0004_0506, 2);
    expect_byte(8'h00);
    compare_log(base, 7);
    // First byte in bits 7:0, second in 15:8, rest zero
    apb_read(REG_RDATA, val);
    check_value("rdata", val, {16'h0, 8'h3C, 8'hA5});
    report_test("address dummy read", errs);
  endtask

  task automatic test_busy();
    int          errs;
    int          base;
    int          frames;
    logic [31:0] val;
    errs   = err_cnt;
    base   = flash.log_cnt;
    frames = flash.frame_cnt;
    @(posedge clk);
    rd_word  <= 32'h1122_3344;
    rd_start <= 4'd4;
    apb_write(REG_ADDR, 32'h0000_1000);
    send_cmd(8'h03, 2'd2, 2'd0, 2'd3, SEQ_CAR);
    apb_read(REG_STATUS, val);
    check_value("status busy", val, 32'h1);
    // Must be dropped while the first frame runs
    send_cmd(8'h9F, 2'd0, 2'd0, 2'd2, SEQ_CR);
    // Command register still holds the first command
    apb_read(REG_CMD, val);
    check_value("cmd", val, {12'h0, SEQ_CAR, 2'b00, 2'd3, 2'd0, 2'd2, 8'h03});
    wait_idle();
    exp_len = 0;
    expect_byte(8'h03);
    expect_addr(32'h0000_1000, 2);
    compare_log(base, 8);
    apb_read(REG_RDATA, val);
    check_value("rdata", val, 32'h4433_2211);
    // Time for a stray start to pull a chip select low
    repeat (20) @(posedge clk);
    check_value("frames", flash.frame_cnt - frames, 32'd1);
    apb_read(REG_STATUS, val);
    check_value("status idle", val, 32'h0);
    report_test("busy and ignored command", errs);
  endtask

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    clk      = 1'b0;
    rstn     = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    rd_word  = '0;
    rd_start = '0;
    cs_clear = 1'b1;
    exp_len  = 0;
    err_cnt  = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    repeat (5) @(posedge clk);
    rstn     <= 1'b1;
    cs_clear <= 1'b0;
    test_reset();
    test_cmd_only();
    test_cmd_addr();
    test_write();
    test_read();
    test_busy();
    $display("Tests: %0d passed, %0d failed, %0d mismatches", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/spim_pkg.sv
rtl/spim_regs.sv
rtl/spim_clkgen.sv
rtl/spim_shift.sv
rtl/spim_seq.sv
rtl/spim_top.sv
sim/spi_flash_model.sv
sim/tb_spim.sv

// ==== Bender.yml ====
package:
  name: spim

sources:
  - rtl/spim_pkg.sv
  - rtl/spim_regs.sv
  - rtl/spim_clkgen.sv
  - rtl/spim_shift.sv
  - rtl/spim_seq.sv
  - rtl/spim_top.sv
  - target: simulation
    files:
      - sim/spi_flash_model.sv
      - sim/tb_spim.sv
